/* Makefile */
# Verilator flow for the convolution CSR block
# Any variable can be overridden, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FILELIST ?= vlog.f
TB_TOP ?= conv_csr_tb
RTL_TOP ?= conv_csr_top
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= No errors
VFLAGS ?= --timing
JOBS ?= 4

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TB_TOP) --Mdir $(BUILD_DIR) -o V$(TB_TOP)

# The log decides pass or fail, not the exit code of the binary
sim: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/conv_csr_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module conv_csr_tb;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 8;
	localparam int CYCLES_PER_CASE = 200;
	localparam int NUM_PARAM_WORDS = 9;

	// AXI side
	logic S_AXI_ACLK = 1'b0;
	logic S_AXI_ARESETN;
	logic [5:0] S_AXI_AWADDR;
	logic S_AXI_AWVALID;
	logic S_AXI_AWREADY;
	logic [31:0] S_AXI_WDATA;
	logic [3:0] S_AXI_WSTRB;
	logic S_AXI_WVALID;
	logic S_AXI_WREADY;
	logic [1:0] S_AXI_BRESP;
	logic S_AXI_BVALID;
	logic S_AXI_BREADY;
	logic [5:0] S_AXI_ARADDR;
	logic S_AXI_ARVALID;
	logic S_AXI_ARREADY;
	logic [31:0] S_AXI_RDATA;
	logic [1:0] S_AXI_RRESP;
	logic S_AXI_RVALID;
	logic S_AXI_RREADY;
	// Accelerator side
	logic running;
	logic compute_done;
	logic exception;
	logic [7:0] kernel_size;
	logic [7:0] stride;
	logic [7:0] padding;
	logic has_bias;
	logic has_relu;
	logic conv_mode;
	logic start;
	logic [31:0] kernel_baseaddr;
	logic [31:0] feature_baseaddr;
	logic [31:0] feature_width;
	logic [31:0] feature_height;
	logic [31:0] feature_chin;
	logic [31:0] feature_chout;
	logic [31:0] output_baseaddr;
	logic [31:0] output_width;
	logic [31:0] output_height;

	// Case table, one entry per operation line
	logic [7:0] op_q[$];
	logic [5:0] addr_q[$];
	logic [31:0] data_q[$];
	logic [3:0] strb_q[$];
	logic [31:0] expect_q[$];
	int num_cases = 0;
	logic cases_loaded = 1'b0;
	// Word indices hit by a write from the case file
	logic [15:0] written_words = '0;

	integer seed = 32'h4c3e9a98;
	// Cycles with start high since the last port check
	int start_cycles = 0;

	conv_csr_top #(
		.NUM_PARAM_WORDS (NUM_PARAM_WORDS)
	) i_conv_csr_top (
		.S_AXI_ACLK (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.S_AXI_AWADDR (S_AXI_AWADDR),
		.S_AXI_AWVALID (S_AXI_AWVALID),
		.S_AXI_AWREADY (S_AXI_AWREADY),
		.S_AXI_WDATA (S_AXI_WDATA),
		.S_AXI_WSTRB (S_AXI_WSTRB),
		.S_AXI_WVALID (S_AXI_WVALID),
		.S_AXI_WREADY (S_AXI_WREADY),
		.S_AXI_BRESP (S_AXI_BRESP),
		.S_AXI_BVALID (S_AXI_BVALID),
		.S_AXI_BREADY (S_AXI_BREADY),
		.S_AXI_ARADDR (S_AXI_ARADDR),
		.S_AXI_ARVALID (S_AXI_ARVALID),
		.S_AXI_ARREADY (S_AXI_ARREADY),
		.S_AXI_RDATA (S_AXI_RDATA),
		.S_AXI_RRESP (S_AXI_RRESP),
		.S_AXI_RVALID (S_AXI_RVALID),
		.S_AXI_RREADY (S_AXI_RREADY),
		.running (running),
		.compute_done (compute_done),
		.exception (exception),
		.kernel_size (kernel_size),
		.stride (stride),
		.padding (padding),
		.has_bias (has_bias),
		.has_relu (has_relu),
		.conv_mode (conv_mode),
		.start (start),
		.kernel_baseaddr (kernel_baseaddr),
		.feature_baseaddr (feature_baseaddr),
		.feature_width (feature_width),
		.feature_height (feature_height),
		.feature_chin (feature_chin),
		.feature_chout (feature_chout),
		.output_baseaddr (output_baseaddr),
		.output_width (output_width),
		.output_height (output_height)
	);

	always #(CLK_PERIOD / 2) S_AXI_ACLK = ~S_AXI_ACLK;

	// Start is sampled mid-cycle, away from the rising edge
	always @(negedge S_AXI_ACLK)
	begin
		if (start === 1'b1)
			start_cycles = start_cycles + 1;
	end

	// ------------------------------------------------------------------------
	// Failure reporting and checks
	// ------------------------------------------------------------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
			abort_run($sformatf("mismatch at %0t ns: %s, got %h, expected %h",
				$time, what, actual, expected));
	endtask

	// Inputs change 1 ns after the rising edge
	task automatic next_cycle;
		@(posedge S_AXI_ACLK);
		#1;
	endtask

	// Port value seen by the accelerator for one word index
	function automatic logic [31:0] port_value(input logic [3:0] index);
		case (index)
			4'd0: port_value = {kernel_size, stride, padding, has_bias, has_relu,
				conv_mode, 5'b00000};
			4'd1: port_value = kernel_baseaddr;
			4'd2: port_value = feature_baseaddr;
			4'd3: port_value = feature_width;
			4'd4: port_value = feature_height;
			4'd5: port_value = feature_chin;
			4'd6: port_value = feature_chout;
			4'd7: port_value = output_baseaddr;
			4'd8: port_value = output_width;
			4'd9: port_value = output_height;
			default: port_value = 32'h0;
		endcase
	endfunction

	// ------------------------------------------------------------------------
	// AXI4-Lite master tasks
	// ------------------------------------------------------------------------
	task automatic axi_write(input logic [5:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		int gap;
		// Address phase
		S_AXI_AWADDR = addr;
		S_AXI_AWVALID = 1'b1;
		while (S_AXI_AWREADY !== 1'b1)
			next_cycle();
		next_cycle();
		S_AXI_AWVALID = 1'b0;
		// Data phase
		S_AXI_WDATA = data;
		S_AXI_WSTRB = strb;
		S_AXI_WVALID = 1'b1;
		while (S_AXI_WREADY !== 1'b1)
			next_cycle();
		next_cycle();
		S_AXI_WVALID = 1'b0;
		// Response, held back for a random number of cycles
		while (S_AXI_BVALID !== 1'b1)
			next_cycle();
		check_value(32'(S_AXI_BRESP), 32'd0, "BRESP not OKAY");
		gap = $unsigned($random(seed)) % 4;
		repeat (gap)
		begin
			next_cycle();
			check_value(32'(S_AXI_BVALID), 32'd1, "BVALID dropped before BREADY");
		end
		S_AXI_BREADY = 1'b1;
		next_cycle();
		S_AXI_BREADY = 1'b0;
		check_value(32'(S_AXI_BVALID), 32'd0, "BVALID still high after accept");
	endtask

	task automatic axi_read(input logic [5:0] addr, output logic [31:0] data);
		int gap;
		S_AXI_ARADDR = addr;
		S_AXI_ARVALID = 1'b1;
		while (S_AXI_ARREADY !== 1'b1)
			next_cycle();
		next_cycle();
		S_AXI_ARVALID = 1'b0;
		while (S_AXI_RVALID !== 1'b1)
			next_cycle();
		data = S_AXI_RDATA;
		check_value(32'(S_AXI_RRESP), 32'd0, "RRESP not OKAY");
		// RDATA has to hold while RREADY is low
		gap = $unsigned($random(seed)) % 4;
		repeat (gap)
		begin
			next_cycle();
			check_value(32'(S_AXI_RVALID), 32'd1, "RVALID dropped before RREADY");
			check_value(S_AXI_RDATA, data, "RDATA changed under back-pressure");
		end
		S_AXI_RREADY = 1'b1;
		next_cycle();
		S_AXI_RREADY = 1'b0;
		check_value(32'(S_AXI_RVALID), 32'd0, "RVALID still high after accept");
	endtask

	// Words never written since reset still read zero at the port and over AXI
	task automatic check_unwritten_words(input logic [15:0] written);
		logic [31:0] rdata;
		logic [5:0] addr;
		for (int idx = 0; idx <= NUM_PARAM_WORDS; idx++)
		begin
			if (!written[idx])
			begin
				addr = 6'(idx << 2);
				check_value(port_value(4'(idx)), 32'h0,
					$sformatf("port value for unwritten index %0d", idx));
				axi_read(addr, rdata);
				check_value(rdata, 32'h0,
					$sformatf("read of unwritten address %h", addr));
			end
		end
	endtask

	// ------------------------------------------------------------------------
	// Case file loader and interpreter
	// ------------------------------------------------------------------------
	task automatic load_cases;
		int fd;
		int count;
		string line;
		logic [7:0] op;
		logic [5:0] addr;
		logic [31:0] data;
		logic [3:0] strb;
		logic [31:0] expected;
		fd = $fopen("bench/csr_cases.txt", "r");
		if (fd == 0)
			abort_run("cannot open the case file bench/csr_cases.txt");
		while (!$feof(fd))
		begin
			line = "";
			count = $fgets(line, fd);
			// Skip comment and blank lines
			if (count == 0 || line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n")
				continue;
			count = $sscanf(line, "%c %h %h %h %h", op, addr, data, strb, expected);
			if (count != 5)
				abort_run($sformatf("malformed line in the case file: %s", line));
			op_q.push_back(op);
			addr_q.push_back(addr);
			data_q.push_back(data);
			strb_q.push_back(strb);
			expect_q.push_back(expected);
		end
		$fclose(fd);
		num_cases = op_q.size();
		cases_loaded = 1'b1;
	endtask

	task automatic run_case(input int i);
		logic [31:0] rdata;
		logic [5:0] addr;
		addr = addr_q[i];
		case (op_q[i])
			"W":
			begin
				axi_write(addr, data_q[i], strb_q[i]);
				written_words[addr[5:2]] = 1'b1;
			end
			"R":
			begin
				axi_read(addr, rdata);
				check_value(rdata, expect_q[i], $sformatf("read at address %h", addr));
			end
			"S":
			begin
				// Status bits take their word 0 positions
				exception = data_q[i][1];
				compute_done = data_q[i][2];
				running = data_q[i][3];
				next_cycle();
			end
			"P":
			begin
				// Let a pending start pulse finish first
				repeat (2)
					next_cycle();
				check_value(port_value(addr[5:2]), expect_q[i],
					$sformatf("port value for index %0d", addr[5:2]));
				check_value(start_cycles, data_q[i], "cycles with start high");
				start_cycles = 0;
			end
			default: abort_run($sformatf("unknown operation in case line %0d", i));
		endcase
	endtask

	// ------------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------------
	initial
	begin
		S_AXI_ARESETN = 1'b0;
		S_AXI_AWADDR = '0;
		S_AXI_AWVALID = 1'b0;
		S_AXI_WDATA = '0;
		S_AXI_WSTRB = '0;
		S_AXI_WVALID = 1'b0;
		S_AXI_BREADY = 1'b0;
		S_AXI_ARADDR = '0;
		S_AXI_ARVALID = 1'b0;
		S_AXI_RREADY = 1'b0;
		running = 1'b0;
		compute_done = 1'b0;
		exception = 1'b0;
		load_cases();
		repeat (RESET_CYCLES)
			@(posedge S_AXI_ACLK);
		#1;
		S_AXI_ARESETN = 1'b1;
		next_cycle();
		// Every word and port starts at zero
		check_unwritten_words(16'h0000);
		for (int i = 0; i < num_cases; i++)
			run_case(i);
		check_unwritten_words(written_words);
		$display("No errors");
		$finish;
	end

	// Watchdog sized from the case lines and the two word sweeps
	initial
	begin
		wait (cases_loaded == 1'b1);
		#(CLK_PERIOD * (RESET_CYCLES
			+ CYCLES_PER_CASE * (num_cases + 2 * (NUM_PARAM_WORDS + 1))));
		abort_run("timeout: the case list did not finish in the allowed time");
	end

endmodule

`default_nettype wire

/* bench/csr_cases.txt */
# op addr data strb expected, all fields hex
# W write, R read, S status on data bits 3:1, P port check with data = start cycles
R 00 00000000 0 00000000
R 04 00000000 0 00000000
R 14 00000000 0 00000000
R 24 00000000 0 00000000
P 00 00000000 0 00000000
P 04 00000000 0 00000000
P 14 00000000 0 00000000
P 20 00000000 0 00000000
P 24 00000000 0 00000000
W 04 11223344 f 00000000
R 04 00000000 0 11223344
W 04 aabbccdd 5 00000000
R 04 00000000 0 11bb33dd
P 04 00000000 0 11bb33dd
W 1c 12345678 c 00000000
R 1c 00000000 0 12340000
P 1c 00000000 0 12340000
W 24 0000abcd 3 00000000
P 24 00000000 0 0000abcd
W 00 030201ff 0 00000000
P 00 00000001 0 030201e0
R 00 00000000 0 030201e0
W 00 05040320 f 00000000
P 00 00000000 0 05040320
S 00 0000000e 0 00000000
R 00 00000000 0 0504032e
S 00 00000014 0 00000000
R 00 00000000 0 05040324
S 00 00000000 0 00000000
R 28 00000000 0 00000000
R 3c 00000000 0 00000000
W 28 ffffffff f 00000000
W 3c deadbeef f 00000000
R 00 00000000 0 05040320
R 04 00000000 0 11bb33dd
R 1c 00000000 0 12340000
R 24 00000000 0 0000abcd
R 3c 00000000 0 00000000
P 00 00000000 0 05040320

/* verilog/conv_csr_top.sv */
`timescale 1ns/100ps
`default_nettype none

module conv_csr_top #(
	parameter int NUM_PARAM_WORDS = 9
) (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	input wire csr_pkg::csr_addr_t S_AXI_AWADDR,
	input wire S_AXI_AWVALID,
	output logic S_AXI_AWREADY,
	input wire csr_pkg::csr_data_t S_AXI_WDATA,
	input wire csr_pkg::csr_strb_t S_AXI_WSTRB,
	input wire S_AXI_WVALID,
	output logic S_AXI_WREADY,
	output logic [1:0] S_AXI_BRESP,
	output logic S_AXI_BVALID,
	input wire S_AXI_BREADY,
	input wire csr_pkg::csr_addr_t S_AXI_ARADDR,
	input wire S_AXI_ARVALID,
	output logic S_AXI_ARREADY,
	output csr_pkg::csr_data_t S_AXI_RDATA,
	output logic [1:0] S_AXI_RRESP,
	output logic S_AXI_RVALID,
	input wire S_AXI_RREADY,
	// Accelerator side
	input wire running,
	input wire compute_done,
	input wire exception,
	output csr_pkg::csr_byte_t kernel_size,
	output csr_pkg::csr_byte_t stride,
	output csr_pkg::csr_byte_t padding,
	output logic has_bias,
	output logic has_relu,
	output logic conv_mode,
	output logic start,
	output csr_pkg::csr_data_t kernel_baseaddr,
	output csr_pkg::csr_data_t feature_baseaddr,
	output csr_pkg::csr_data_t feature_width,
	output csr_pkg::csr_data_t feature_height,
	output csr_pkg::csr_data_t feature_chin,
	output csr_pkg::csr_data_t feature_chout,
	output csr_pkg::csr_data_t output_baseaddr,
	output csr_pkg::csr_data_t output_width,
	output csr_pkg::csr_data_t output_height
);
	import csr_pkg::*;

	// Named parameter ports, missing words read as zero
	localparam int NUM_NAMED_WORDS = 9;
	localparam int PAD_WORDS =
		(NUM_PARAM_WORDS > NUM_NAMED_WORDS) ? NUM_PARAM_WORDS : NUM_NAMED_WORDS;

	logic [NUM_PARAM_WORDS:0] wr_sel;
	csr_data_t csr_wdata;
	csr_strb_t csr_wstrb;
	csr_data_t ctrl_rdata;
	logic [NUM_PARAM_WORDS*CSR_DATA_W-1:0] param_words;
	logic [PAD_WORDS*CSR_DATA_W-1:0] param_named;

	// Always OKAY
	assign S_AXI_BRESP = AXI_RESP_OKAY;
	assign S_AXI_RRESP = AXI_RESP_OKAY;

	csr_write_channel #(
		.NUM_PARAM_WORDS (NUM_PARAM_WORDS)
	) i_write_channel (
		.S_AXI_ACLK (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.S_AXI_AWADDR (S_AXI_AWADDR),
		.S_AXI_AWVALID (S_AXI_AWVALID),
		.S_AXI_AWREADY (S_AXI_AWREADY),
		.S_AXI_WDATA (S_AXI_WDATA),
		.S_AXI_WSTRB (S_AXI_WSTRB),
		.S_AXI_WVALID (S_AXI_WVALID),
		.S_AXI_WREADY (S_AXI_WREADY),
		.S_AXI_BVALID (S_AXI_BVALID),
		.S_AXI_BREADY (S_AXI_BREADY),
		.wr_sel (wr_sel),
		.wr_data (csr_wdata),
		.wr_strb (csr_wstrb)
	);

	csr_ctrl_reg i_ctrl_reg (
		.S_AXI_ACLK (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.wr_sel_ctrl (wr_sel[CTRL_INDEX]),
		.wr_data (csr_wdata),
		.running (running),
		.compute_done (compute_done),
		.exception (exception),
		.kernel_size (kernel_size),
		.stride (stride),
		.padding (padding),
		.has_bias (has_bias),
		.has_relu (has_relu),
		.conv_mode (conv_mode),
		.start (start),
		.ctrl_rdata (ctrl_rdata)
	);

	// ------------------------------------------------------------------------
	// Parameter words, one register per index
	// ------------------------------------------------------------------------
	for (genvar k = 0; k < NUM_PARAM_WORDS; k++)
	begin : g_param
		csr_param_word i_param_word (
			.S_AXI_ACLK (S_AXI_ACLK),
			.S_AXI_ARESETN (S_AXI_ARESETN),
			.wr_en (wr_sel[k + PARAM_BASE_INDEX]),
			.wr_data (csr_wdata),
			.wr_strb (csr_wstrb),
			.word (param_words[k*CSR_DATA_W +: CSR_DATA_W])
		);
	end

	csr_read_channel #(
		.NUM_PARAM_WORDS (NUM_PARAM_WORDS)
	) i_read_channel (
		.S_AXI_ACLK (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.S_AXI_ARADDR (S_AXI_ARADDR),
		.S_AXI_ARVALID (S_AXI_ARVALID),
		.S_AXI_ARREADY (S_AXI_ARREADY),
		.S_AXI_RDATA (S_AXI_RDATA),
		.S_AXI_RVALID (S_AXI_RVALID),
		.S_AXI_RREADY (S_AXI_RREADY),
		.ctrl_rdata (ctrl_rdata),
		.param_words (param_words)
	);

	// Zero-extend so every named port has a source
	assign param_named = (PAD_WORDS*CSR_DATA_W)'(param_words);

	assign kernel_baseaddr = param_named[0*CSR_DATA_W +: CSR_DATA_W];
	assign feature_baseaddr = param_named[1*CSR_DATA_W +: CSR_DATA_W];
	assign feature_width = param_named[2*CSR_DATA_W +: CSR_DATA_W];
	assign feature_height = param_named[3*CSR_DATA_W +: CSR_DATA_W];
	assign feature_chin = param_named[4*CSR_DATA_W +: CSR_DATA_W];
	assign feature_chout = param_named[5*CSR_DATA_W +: CSR_DATA_W];
	assign output_baseaddr = param_named[6*CSR_DATA_W +: CSR_DATA_W];
	assign output_width = param_named[7*CSR_DATA_W +: CSR_DATA_W];
	assign output_height = param_named[8*CSR_DATA_W +: CSR_DATA_W];

endmodule

`default_nettype wire

/* verilog/csr_ctrl_reg.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_ctrl_reg (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	input wire wr_sel_ctrl,
	input wire csr_pkg::csr_data_t wr_data,
	input wire running,
	input wire compute_done,
	input wire exception,
	output csr_pkg::csr_byte_t kernel_size,
	output csr_pkg::csr_byte_t stride,
	output csr_pkg::csr_byte_t padding,
	output logic has_bias,
	output logic has_relu,
	output logic conv_mode,
	output logic start,
	output csr_pkg::csr_data_t ctrl_rdata
);
	import csr_pkg::*;

	// Word 0 fields, strobes ignored
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			kernel_size <= '0;
			stride <= '0;
			padding <= '0;
			has_bias <= 1'b0;
			has_relu <= 1'b0;
			conv_mode <= 1'b0;
			start <= 1'b0;
		end
		else
		begin
			// Start pulses for a single cycle
			start <= 1'b0;
			if (wr_sel_ctrl)
			begin
				start <= wr_data[START_BIT];
				conv_mode <= wr_data[CONV_MODE_BIT];
				has_relu <= wr_data[HAS_RELU_BIT];
				has_bias <= wr_data[HAS_BIAS_BIT];
				padding <= wr_data[PADDING_LSB +: $bits(csr_byte_t)];
				stride <= wr_data[STRIDE_LSB +: $bits(csr_byte_t)];
				kernel_size <= wr_data[KERNEL_SIZE_LSB +: $bits(csr_byte_t)];
			end
		end
	end

	// Readback, status bits are live inputs
	always_comb
	begin
		ctrl_rdata = '0;
		ctrl_rdata[START_BIT] = start;
		ctrl_rdata[EXCEPTION_BIT] = exception;
		ctrl_rdata[DONE_BIT] = compute_done;
		ctrl_rdata[RUNNING_BIT] = running;
		ctrl_rdata[RSVD_BIT] = 1'b0;
		ctrl_rdata[CONV_MODE_BIT] = conv_mode;
		ctrl_rdata[HAS_RELU_BIT] = has_relu;
		ctrl_rdata[HAS_BIAS_BIT] = has_bias;
		ctrl_rdata[PADDING_LSB +: $bits(csr_byte_t)] = padding;
		ctrl_rdata[STRIDE_LSB +: $bits(csr_byte_t)] = stride;
		ctrl_rdata[KERNEL_SIZE_LSB +: $bits(csr_byte_t)] = kernel_size;
	end

endmodule

`default_nettype wire

/* verilog/csr_param_word.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_param_word (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	input wire wr_en,
	input wire csr_pkg::csr_data_t wr_data,
	input wire csr_pkg::csr_strb_t wr_strb,
	output csr_pkg::csr_data_t word
);
	import csr_pkg::*;

	// Byte lanes follow the write strobes
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			word <= '0;
		end
		else if (wr_en)
		begin
			for (int b = 0; b < CSR_STRB_W; b++)
			begin
				// Untouched lanes keep their value
				if (wr_strb[b])
					word[b*8 +: 8] <= wr_data[b*8 +: 8];
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/csr_pkg.sv */
`default_nettype none

package csr_pkg;

	// Bus widths
	localparam int CSR_DATA_W = 32;
	localparam int CSR_STRB_W = CSR_DATA_W / 8;

	typedef logic [CSR_DATA_W-1:0] csr_data_t;
	typedef logic [5:0] csr_addr_t;
	typedef logic [CSR_STRB_W-1:0] csr_strb_t;
	typedef logic [3:0] csr_index_t;
	typedef logic [7:0] csr_byte_t;

	// Word map, index taken from byte address bits 5:2
	localparam int CSR_ADDR_LSB = 2;
	localparam csr_index_t CTRL_INDEX = 4'd0;
	// Parameter word k lives at index k+1
	localparam int PARAM_BASE_INDEX = 1;

	// ------------------------------------------------------------------------
	// Control word 0 layout
	// ------------------------------------------------------------------------
	localparam int START_BIT = 0;
	localparam int EXCEPTION_BIT = 1;
	localparam int DONE_BIT = 2;
	localparam int RUNNING_BIT = 3;
	localparam int RSVD_BIT = 4;
	localparam int CONV_MODE_BIT = 5;
	localparam int HAS_RELU_BIT = 6;
	localparam int HAS_BIAS_BIT = 7;
	localparam int PADDING_LSB = 8;
	localparam int STRIDE_LSB = 16;
	localparam int KERNEL_SIZE_LSB = 24;

	localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

	typedef enum logic [1:0] {wr_idle, wr_addr, wr_data} wr_state_t;
	typedef enum logic [1:0] {rd_idle, rd_addr, rd_data} rd_state_t;

endpackage

`default_nettype wire

/* verilog/csr_read_channel.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_read_channel #(
	parameter int NUM_PARAM_WORDS = 9
) (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	input wire csr_pkg::csr_addr_t S_AXI_ARADDR,
	input wire S_AXI_ARVALID,
	output logic S_AXI_ARREADY,
	output csr_pkg::csr_data_t S_AXI_RDATA,
	output logic S_AXI_RVALID,
	input wire S_AXI_RREADY,
	input wire csr_pkg::csr_data_t ctrl_rdata,
	input wire [NUM_PARAM_WORDS*csr_pkg::CSR_DATA_W-1:0] param_words
);
	import csr_pkg::*;

	rd_state_t state;
	csr_index_t rd_index;

	// ------------------------------------------------------------------------
	// Read handshake FSM
	// ------------------------------------------------------------------------
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			state <= rd_idle;
			S_AXI_ARREADY <= 1'b0;
			S_AXI_RVALID <= 1'b0;
			rd_index <= '0;
		end
		else
		begin
			case (state)
				rd_idle:
				begin
					S_AXI_ARREADY <= 1'b1;
					state <= rd_addr;
				end
				rd_addr:
				begin
					// Latch index, data follows on next cycle
					if (S_AXI_ARVALID && S_AXI_ARREADY)
					begin
						rd_index <= S_AXI_ARADDR[CSR_ADDR_LSB +: $bits(csr_index_t)];
						S_AXI_ARREADY <= 1'b0;
						S_AXI_RVALID <= 1'b1;
						state <= rd_data;
					end
				end
				rd_data:
				begin
					// Hold RVALID under back-pressure
					if (S_AXI_RVALID && S_AXI_RREADY)
					begin
						S_AXI_RVALID <= 1'b0;
						S_AXI_ARREADY <= 1'b1;
						state <= rd_addr;
					end
				end
				default: state <= rd_idle;
			endcase
		end
	end

	// Readback mux on latched index
	// Unmapped indices return zero
	always_comb
	begin
		S_AXI_RDATA = '0;
		if (rd_index == CTRL_INDEX)
			S_AXI_RDATA = ctrl_rdata;
		for (int k = 0; k < NUM_PARAM_WORDS; k++)
		begin
			if (rd_index == csr_index_t'(k + PARAM_BASE_INDEX))
				S_AXI_RDATA = param_words[k*CSR_DATA_W +: CSR_DATA_W];
		end
	end

endmodule

`default_nettype wire

/* verilog/csr_write_channel.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_write_channel #(
	parameter int NUM_PARAM_WORDS = 9
) (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	input wire csr_pkg::csr_addr_t S_AXI_AWADDR,
	input wire S_AXI_AWVALID,
	output logic S_AXI_AWREADY,
	input wire csr_pkg::csr_data_t S_AXI_WDATA,
	input wire csr_pkg::csr_strb_t S_AXI_WSTRB,
	input wire S_AXI_WVALID,
	output logic S_AXI_WREADY,
	output logic S_AXI_BVALID,
	input wire S_AXI_BREADY,
	output logic [NUM_PARAM_WORDS:0] wr_sel,
	output csr_pkg::csr_data_t wr_data,
	output csr_pkg::csr_strb_t wr_strb
);
	import csr_pkg::*;

	wr_state_t state;
	csr_index_t wr_index;
	logic [NUM_PARAM_WORDS:0] sel_decode;

	// One-hot decode of latched word index
	// Index beyond the last parameter word gives no select
	always_comb
	begin
		sel_decode = '0;
		for (int i = 0; i <= NUM_PARAM_WORDS; i++)
		begin
			if (wr_index == csr_index_t'(i))
				sel_decode[i] = 1'b1;
		end
	end

	// ------------------------------------------------------------------------
	// Write handshake FSM
	// ------------------------------------------------------------------------
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			state <= wr_idle;
			S_AXI_AWREADY <= 1'b0;
			S_AXI_WREADY <= 1'b0;
			S_AXI_BVALID <= 1'b0;
			wr_sel <= '0;
		end
		else
		begin
			// Select only lasts one cycle
			wr_sel <= '0;
			// Response held until master takes it
			if (S_AXI_BVALID && S_AXI_BREADY)
				S_AXI_BVALID <= 1'b0;
			case (state)
				wr_idle:
				begin
					S_AXI_AWREADY <= 1'b1;
					state <= wr_addr;
				end
				wr_addr:
				begin
					if (S_AXI_AWVALID && S_AXI_AWREADY)
					begin
						S_AXI_AWREADY <= 1'b0;
						S_AXI_WREADY <= 1'b1;
						// Port wr_data hides the state literal
						state <= csr_pkg::wr_data;
					end
				end
				csr_pkg::wr_data:
				begin
					if (S_AXI_WREADY)
					begin
						if (S_AXI_WVALID)
							S_AXI_WREADY <= 1'b0;
					end
					else
					begin
						// Beat captured on previous edge, commit and respond
						wr_sel <= sel_decode;
						S_AXI_BVALID <= 1'b1;
						S_AXI_AWREADY <= 1'b1;
						state <= wr_addr;
					end
				end
				default: state <= wr_idle;
			endcase
		end
	end

	// Address index and data beat capture
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (S_AXI_AWVALID && S_AXI_AWREADY)
			wr_index <= S_AXI_AWADDR[CSR_ADDR_LSB +: $bits(csr_index_t)];
		if (S_AXI_WVALID && S_AXI_WREADY)
		begin
			wr_data <= S_AXI_WDATA;
			wr_strb <= S_AXI_WSTRB;
		end
	end

endmodule

`default_nettype wire

/* vlog.f */
verilog/csr_pkg.sv
verilog/csr_write_channel.sv
verilog/csr_param_word.sv
verilog/csr_ctrl_reg.sv
verilog/csr_read_channel.sv
verilog/conv_csr_top.sv
bench/conv_csr_tb.sv
